// ==== Bender.yml ====
package:
  name: pipe_core

export_include_dirs:
  - hw

sources:
  - files:
      - hw/core_pkg.sv
      - hw/inst_decoder.sv
      - hw/reg_file.sv
      - hw/alu.sv
      - hw/branch_cmp.sv
      - hw/next_pc_sel.sv
      - hw/pipe_core.sv
  - target: simulation
    files:
      - dv/core_checker.sv
      - dv/core_sva.sv
      - dv/core_tb.sv

// ==== dv/core_checker.sv ====
`include "core_defines.svh"

module core_checker (
    input  logic                    clk,
    input  logic                    reg_strobe,
    input  logic                    pc_strobe,
    input  logic                    done,
    input  logic [`CORE_REG_AW-1:0] check_addr,
    input  logic [`CORE_XLEN-1:0]   check_data,
    input  logic [`CORE_XLEN-1:0]   im_addr,
    input  logic [`CORE_XLEN-1:0]   expected,
    output int                      pass_count,
    output int                      fail_count
);
    timeunit 1ns;
    timeprecision 1ps;

    int test_num;

    initial begin
        test_num   = 0;
        pass_count = 0;
        fail_count = 0;
    end

    task automatic compare(input string name,
                           input logic [`CORE_XLEN-1:0] got,
                           input logic [`CORE_XLEN-1:0] exp);
        test_num++;
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h (test %0d)",
                     name, got, exp, test_num);
            fail_count++;
        end else begin
            $display("Test %0d %s = 0x%08h ok", test_num, name, got);
            pass_count++;
        end
    endtask

    // Inputs change on the edge by NBA, so old values are seen here
    always @(posedge clk) begin
        if (pc_strobe)
            compare("im_addr", im_addr, expected);
        if (reg_strobe)
            compare($sformatf("x%0d", check_addr), check_data, expected);
        if (done)
            $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
    end

endmodule

// ==== dv/core_sva.sv ====
`include "core_defines.svh"

module core_sva (
    input logic                    clk,
    input logic                    reset,
    input logic [`CORE_XLEN-1:0]   pc,
    input logic                    flush_if_id,
    input logic [`CORE_REG_AW-1:0] check_addr,
    input logic [`CORE_XLEN-1:0]   check_data
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;

    a_reset_pc: assert property (@(posedge clk) reset |=> pc == `CORE_RESET_PC)
        else begin
            assert_fails++;
            $error("PC is not the reset address after a reset edge");
        end

    a_x0_zero: assert property (@(posedge clk) check_addr == '0 |-> check_data == '0)
        else begin
            assert_fails++;
            $error("x0 reads nonzero on the debug port");
        end

    a_seq_pc: assert property (@(posedge clk) disable iff (reset)
        !reset && !flush_if_id |=> pc == $past(pc) + 32'd4)
        else begin
            assert_fails++;
            $error("PC did not advance by 4 without a redirect");
        end

endmodule

// ==== dv/core_tb.sv ====
`include "core_defines.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROM_LEN = 32;
    localparam int CHECK_LEN = 29;
    localparam int TIMEOUT_CYCLES = 3 * ROM_LEN + CHECK_LEN + 20;

    logic                    clk;
    logic                    reset;
    logic [`CORE_XLEN-1:0]   im_addr;
    logic [`CORE_XLEN-1:0]   im_dout;
    logic [`CORE_REG_AW-1:0] check_addr;
    logic [`CORE_XLEN-1:0]   check_data;
    logic [`CORE_XLEN-1:0]   expected;
    logic                    reg_strobe;
    logic                    pc_strobe;
    logic                    done;
    int                      pass_count;
    int                      fail_count;
    int                      cycle_count = 0;

    logic [`CORE_XLEN-1:0] rom [ROM_LEN] = '{
        32'h00500093, // 00 addi x1, x0, 5
        32'hFFD08113, // 04 addi x2, x1, -3
        32'h002081B3, // 08 add  x3, x1, x2
        32'h40110233, // 0C sub  x4, x2, x1
        32'h001242B3, // 10 xor  x5, x4, x1
        32'h40225333, // 14 sra  x6, x4, x2
        32'h01C25393, // 18 srli x7, x4, 28
        32'h00122433, // 1C slt  x8, x4, x1
        32'h0040B4B3, // 20 sltu x9, x1, x4
        32'h12345537, // 24 lui  x10, 0x12345
        32'h00001597, // 28 auipc x11, 0x1
        32'h00108663, // 2C beq  x1, x1, +12
        32'h00100613, // 30 addi x12, x0, 1
        32'h00100693, // 34 addi x13, x0, 1
        32'h00109663, // 38 bne  x1, x1, +12
        32'h00E00713, // 3C addi x14, x0, 14
        32'h00F00793, // 40 addi x15, x0, 15
        32'h0080086F, // 44 jal  x16, +8
        32'h00100893, // 48 addi x17, x0, 1
        32'h05308967, // 4C jalr x18, 0x53(x1)
        32'h00100993, // 50 addi x19, x0, 1
        32'h00100A13, // 54 addi x20, x0, 1
        32'h00156AB3, // 58 or   x21, x10, x1
        32'h0F02FB13, // 5C andi x22, x5, 0xF0
        32'h00409B93, // 60 slli x23, x1, 4
        32'h00708013, // 64 addi x0, x1, 7
        32'h00124663, // 68 blt  x4, x1, +12
        32'h00100C13, // 6C addi x24, x0, 1
        32'h00100C93, // 70 addi x25, x0, 1
        32'h00126463, // 74 bltu x4, x1, +8
        32'h01A00D13, // 78 addi x26, x0, 26
        32'h0000006F  // 7C jal  x0, 0
    };

    // Register number and value after the program settles
    logic [`CORE_REG_AW+`CORE_XLEN-1:0] check_table [CHECK_LEN] = '{
        {5'd0, 32'h00000000}, {5'd1, 32'h00000005}, {5'd2, 32'h00000002},
        {5'd3, 32'h00000007}, {5'd4, 32'hFFFFFFFD}, {5'd5, 32'hFFFFFFF8},
        {5'd6, 32'hFFFFFFFF}, {5'd7, 32'h0000000F}, {5'd8, 32'h00000001},
        {5'd9, 32'h00000001}, {5'd10, 32'h12345000}, {5'd11, 32'h00001028},
        {5'd12, 32'h00000000}, {5'd13, 32'h00000000}, {5'd14, 32'h0000000E},
        {5'd15, 32'h0000000F}, {5'd16, 32'h00000048}, {5'd17, 32'h00000000},
        {5'd18, 32'h00000050}, {5'd19, 32'h00000000}, {5'd20, 32'h00000000},
        {5'd21, 32'h12345005}, {5'd22, 32'h000000F0}, {5'd23, 32'h00000050},
        {5'd24, 32'h00000000}, {5'd25, 32'h00000000}, {5'd26, 32'h0000001A},
        {5'd27, 32'h00000000}, {5'd31, 32'h00000000}
    };

    assign im_dout = (im_addr < 4 * ROM_LEN) ? rom[im_addr[6:2]] : `CORE_NOP;

    pipe_core DUT (
        .clk        (clk),
        .reset      (reset),
        .im_addr    (im_addr),
        .im_dout    (im_dout),
        .check_addr (check_addr),
        .check_data (check_data)
    );

    bind pipe_core core_sva u_sva (
        .clk         (clk),
        .reset       (reset),
        .pc          (pc),
        .flush_if_id (flush_if_id),
        .check_addr  (check_addr),
        .check_data  (check_data)
    );

    core_checker u_checker (
        .clk        (clk),
        .reg_strobe (reg_strobe),
        .pc_strobe  (pc_strobe),
        .done       (done),
        .check_addr (check_addr),
        .check_data (check_data),
        .im_addr    (im_addr),
        .expected   (expected),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        reset      = 1'b1;
        check_addr = '0;
        expected   = '0;
        reg_strobe = 1'b0;
        pc_strobe  = 1'b0;
        done       = 1'b0;
        @(posedge clk);
        pc_strobe <= 1'b1; // Fetch address while in reset
        expected  <= `CORE_RESET_PC;
        @(posedge clk);
        pc_strobe  <= 1'b0;
        reg_strobe <= 1'b1; // x1 cleared by reset
        check_addr <= 5'd1;
        expected   <= '0;
        @(posedge clk);
        reset      <= 1'b0;
        reg_strobe <= 1'b0;
        check_addr <= '0;
        repeat (3 * ROM_LEN) @(posedge clk);
        for (int i = 0; i < CHECK_LEN; i++) begin
            check_addr <= check_table[i][`CORE_REG_AW+`CORE_XLEN-1:`CORE_XLEN];
            expected   <= check_table[i][`CORE_XLEN-1:0];
            reg_strobe <= 1'b1;
            @(posedge clk);
        end
        reg_strobe <= 1'b0;
        done       <= 1'b1;
        @(posedge clk);
        done <= 1'b0;
        @(posedge clk);
        if (pass_count + fail_count != CHECK_LEN + 2)
            $display("Not every check ran: %0d of %0d", pass_count + fail_count, CHECK_LEN + 2);
        if (DUT.u_sva.assert_fails != 0)
            $display("Assertions failed %0d times", DUT.u_sva.assert_fails);
        if (fail_count == 0 && pass_count == CHECK_LEN + 2 && DUT.u_sva.assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== hw/alu.sv ====
`include "core_defines.svh"

module alu (
    input  logic [`CORE_XLEN-1:0] src1,
    input  logic [`CORE_XLEN-1:0] src2,
    input  core_pkg::alu_op_e     op,
    output logic [`CORE_XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            core_pkg::ALU_ADD:  result = src1 + src2;
            core_pkg::ALU_SUB:  result = src1 - src2;
            core_pkg::ALU_AND:  result = src1 & src2;
            core_pkg::ALU_OR:   result = src1 | src2;
            core_pkg::ALU_XOR:  result = src1 ^ src2;
            core_pkg::ALU_SLL:  result = src1 << shamt;
            core_pkg::ALU_SRL:  result = src1 >> shamt;
            core_pkg::ALU_SRA:  result = $signed(src1) >>> shamt;
            core_pkg::ALU_SLT:  result = {31'b0, $signed(src1) < $signed(src2)};
            core_pkg::ALU_SLTU: result = {31'b0, src1 < src2};
            default:            result = '0;
        endcase
    end

endmodule

// ==== hw/branch_cmp.sv ====
`include "core_defines.svh"

module branch_cmp (
    input  logic [`CORE_XLEN-1:0] op1,
    input  logic [`CORE_XLEN-1:0] op2,
    input  core_pkg::br_type_e    br_type,
    output logic                  taken
);

    always_comb begin
        case (br_type)
            core_pkg::BR_EQ:  taken = (op1 == op2);
            core_pkg::BR_NE:  taken = (op1 != op2);
            core_pkg::BR_LT:  taken = ($signed(op1) < $signed(op2));
            core_pkg::BR_LTU: taken = (op1 < op2);
            default:          taken = 1'b0; // Not a branch
        endcase
    end

endmodule

// ==== hw/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Word width for data and addresses
`define CORE_XLEN 32

// Register index width
`define CORE_REG_AW 5

`define CORE_RESET_PC 32'h00000000

// ADDI x0, x0, 0
`define CORE_NOP 32'h00000013

`endif

// ==== hw/core_pkg.sv ====
package core_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_LTU} br_type_e;

    typedef enum logic [1:0] {PC_SEQ, PC_BR, PC_JALR, PC_JAL_ID} pc_sel_e;

    typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_IMM} wb_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } inst_t;

endpackage

// ==== hw/inst_decoder.sv ====
`include "core_defines.svh"

module inst_decoder (
    input  core_pkg::inst_t        inst,
    output logic [`CORE_XLEN-1:0]  imm,
    output core_pkg::alu_op_e      alu_op,
    output logic                   alu_src1_pc,
    output logic                   alu_src2_imm,
    output core_pkg::br_type_e     br_type,
    output logic                   jal,
    output logic                   jalr,
    output logic                   rf_we,
    output core_pkg::wb_sel_e      wb_sel
);

    // Shared funct3 map for OP and OP-IMM, alt picks SUB or SRA
    function automatic core_pkg::alu_op_e alu_from_funct3(input logic [2:0] funct3,
                                                          input logic       alt);
        case (funct3)
            3'b000:  return alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  return core_pkg::ALU_SLL;
            3'b010:  return core_pkg::ALU_SLT;
            3'b011:  return core_pkg::ALU_SLTU;
            3'b100:  return core_pkg::ALU_XOR;
            3'b101:  return alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  return core_pkg::ALU_OR;
            default: return core_pkg::ALU_AND;
        endcase
    endfunction

    logic we_raw;

    always_comb begin
        imm          = '0;
        alu_op       = core_pkg::ALU_ADD;
        alu_src1_pc  = 1'b0;
        alu_src2_imm = 1'b0;
        br_type      = core_pkg::BR_NONE;
        jal          = 1'b0;
        jalr         = 1'b0;
        we_raw       = 1'b0;
        wb_sel       = core_pkg::WB_ALU;
        case (inst.r.opcode)
            core_pkg::OP_REG: begin
                alu_op = alu_from_funct3(inst.r.funct3, inst.r.funct7[5]);
                we_raw = 1'b1;
            end
            core_pkg::OP_IMM: begin
                imm          = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
                alu_op       = alu_from_funct3(inst.i.funct3,
                                               (inst.i.funct3 == 3'b101) & inst.r.funct7[5]);
                alu_src2_imm = 1'b1;
                we_raw       = 1'b1;
            end
            core_pkg::OP_LUI: begin
                imm    = {inst.u.imm_31_12, 12'b0};
                wb_sel = core_pkg::WB_IMM;
                we_raw = 1'b1;
            end
            core_pkg::OP_AUIPC: begin
                imm          = {inst.u.imm_31_12, 12'b0};
                alu_src1_pc  = 1'b1;
                alu_src2_imm = 1'b1;
                we_raw       = 1'b1;
            end
            core_pkg::OP_JAL: begin
                imm    = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                          inst.j.imm_11, inst.j.imm_10_1, 1'b0};
                jal    = 1'b1;
                wb_sel = core_pkg::WB_PC4;
                we_raw = 1'b1;
            end
            core_pkg::OP_JALR: begin
                imm          = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
                alu_src2_imm = 1'b1;
                jalr         = 1'b1;
                wb_sel       = core_pkg::WB_PC4;
                we_raw       = 1'b1;
            end
            core_pkg::OP_BRANCH: begin
                imm          = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                                inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
                alu_src1_pc  = 1'b1; // ALU forms the target
                alu_src2_imm = 1'b1;
                case (inst.b.funct3)
                    3'b000:  br_type = core_pkg::BR_EQ;
                    3'b001:  br_type = core_pkg::BR_NE;
                    3'b100:  br_type = core_pkg::BR_LT;
                    3'b110:  br_type = core_pkg::BR_LTU;
                    default: br_type = core_pkg::BR_NONE;
                endcase
            end
            default: ; // Unsupported opcode runs as a bubble
        endcase
    end

    assign rf_we = we_raw & (inst.r.rd != '0);

endmodule

// ==== hw/next_pc_sel.sv ====
`include "core_defines.svh"

module next_pc_sel (
    input  logic [`CORE_XLEN-1:0] pc_add4,
    input  logic [`CORE_XLEN-1:0] alu_result,
    input  logic [`CORE_XLEN-1:0] jal_target,
    input  logic                  taken,
    input  logic                  jalr,
    input  logic                  jal_id,
    output logic [`CORE_XLEN-1:0] next_pc,
    output logic                  flush_if_id,
    output logic                  flush_id_ex
);

    core_pkg::pc_sel_e pc_sel;

    // EX redirects are older, so they win over a JAL in ID
    always_comb begin
        if (taken)
            pc_sel = core_pkg::PC_BR;
        else if (jalr)
            pc_sel = core_pkg::PC_JALR;
        else if (jal_id)
            pc_sel = core_pkg::PC_JAL_ID;
        else
            pc_sel = core_pkg::PC_SEQ;
    end

    always_comb begin
        case (pc_sel)
            core_pkg::PC_BR:     next_pc = alu_result;
            core_pkg::PC_JALR:   next_pc = {alu_result[`CORE_XLEN-1:1], 1'b0};
            core_pkg::PC_JAL_ID: next_pc = jal_target;
            default:             next_pc = pc_add4;
        endcase
    end

    assign flush_if_id = (pc_sel != core_pkg::PC_SEQ);
    assign flush_id_ex = (pc_sel == core_pkg::PC_BR) || (pc_sel == core_pkg::PC_JALR);

endmodule

// ==== hw/pipe_core.sv ====
`include "core_defines.svh"

module pipe_core (
    input  logic                    clk,
    input  logic                    reset,
    output logic [`CORE_XLEN-1:0]   im_addr,
    input  logic [`CORE_XLEN-1:0]   im_dout,
    input  logic [`CORE_REG_AW-1:0] check_addr,
    output logic [`CORE_XLEN-1:0]   check_data
);

    // IF
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] pc_add4;
    logic [`CORE_XLEN-1:0] next_pc;
    logic                  flush_if_id;
    logic                  flush_id_ex;

    // ID
    core_pkg::inst_t       id_inst;
    logic [`CORE_XLEN-1:0] id_pc;
    logic [`CORE_XLEN-1:0] id_imm;
    logic [`CORE_XLEN-1:0] id_rs1_val;
    logic [`CORE_XLEN-1:0] id_rs2_val;
    logic [`CORE_XLEN-1:0] id_jal_target;
    core_pkg::alu_op_e     id_alu_op;
    logic                  id_src1_pc;
    logic                  id_src2_imm;
    core_pkg::br_type_e    id_br_type;
    logic                  id_jal;
    logic                  id_jalr;
    logic                  id_rf_we;
    core_pkg::wb_sel_e     id_wb_sel;

    // EX
    core_pkg::inst_t       ex_inst;
    logic [`CORE_XLEN-1:0] ex_pc;
    logic [`CORE_XLEN-1:0] ex_imm;
    logic [`CORE_XLEN-1:0] ex_rs1_val;
    logic [`CORE_XLEN-1:0] ex_rs2_val;
    core_pkg::alu_op_e     ex_alu_op;
    logic                  ex_src1_pc;
    logic                  ex_src2_imm;
    core_pkg::br_type_e    ex_br_type;
    logic                  ex_jalr;
    logic                  ex_rf_we;
    core_pkg::wb_sel_e     ex_wb_sel;
    logic [`CORE_XLEN-1:0] ex_src1;
    logic [`CORE_XLEN-1:0] ex_src2;
    logic [`CORE_XLEN-1:0] ex_alu_result;
    logic                  ex_taken;
    logic [`CORE_XLEN-1:0] ex_wb_data;

    assign im_addr = pc;
    assign pc_add4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= `CORE_RESET_PC;
        else
            pc <= next_pc;
    end

    always_ff @(posedge clk) begin
        if (reset || flush_if_id)
            id_inst <= `CORE_NOP; // Squash the wrong-path fetch
        else
            id_inst <= im_dout;
        id_pc <= pc;
    end

    inst_decoder u_decoder (
        .inst         (id_inst),
        .imm          (id_imm),
        .alu_op       (id_alu_op),
        .alu_src1_pc  (id_src1_pc),
        .alu_src2_imm (id_src2_imm),
        .br_type      (id_br_type),
        .jal          (id_jal),
        .jalr         (id_jalr),
        .rf_we        (id_rf_we),
        .wb_sel       (id_wb_sel)
    );

    assign id_jal_target = id_pc + id_imm; // JAL resolved early

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .ra0    (id_inst.r.rs1),
        .ra1    (id_inst.r.rs2),
        .rd0    (id_rs1_val),
        .rd1    (id_rs2_val),
        .wa     (ex_inst.r.rd),
        .wd     (ex_wb_data),
        .we     (ex_rf_we),
        .ra_dbg (check_addr),
        .rd_dbg (check_data)
    );

    always_ff @(posedge clk) begin
        if (reset || flush_id_ex) begin
            ex_inst    <= `CORE_NOP;
            ex_rf_we   <= 1'b0;
            ex_br_type <= core_pkg::BR_NONE;
            ex_jalr    <= 1'b0;
        end else begin
            ex_inst    <= id_inst;
            ex_rf_we   <= id_rf_we;
            ex_br_type <= id_br_type;
            ex_jalr    <= id_jalr;
        end
        ex_pc       <= id_pc;
        ex_imm      <= id_imm;
        ex_rs1_val  <= id_rs1_val;
        ex_rs2_val  <= id_rs2_val;
        ex_alu_op   <= id_alu_op;
        ex_src1_pc  <= id_src1_pc;
        ex_src2_imm <= id_src2_imm;
        ex_wb_sel   <= id_wb_sel;
    end

    assign ex_src1 = ex_src1_pc ? ex_pc : ex_rs1_val;
    assign ex_src2 = ex_src2_imm ? ex_imm : ex_rs2_val;

    alu u_alu (
        .src1   (ex_src1),
        .src2   (ex_src2),
        .op     (ex_alu_op),
        .result (ex_alu_result)
    );

    // Compares the raw register values while the ALU builds the target
    branch_cmp u_branch_cmp (
        .op1     (ex_rs1_val),
        .op2     (ex_rs2_val),
        .br_type (ex_br_type),
        .taken   (ex_taken)
    );

    next_pc_sel u_next_pc_sel (
        .pc_add4     (pc_add4),
        .alu_result  (ex_alu_result),
        .jal_target  (id_jal_target),
        .taken       (ex_taken),
        .jalr        (ex_jalr),
        .jal_id      (id_jal),
        .next_pc     (next_pc),
        .flush_if_id (flush_if_id),
        .flush_id_ex (flush_id_ex)
    );

    always_comb begin
        case (ex_wb_sel)
            core_pkg::WB_PC4: ex_wb_data = ex_pc + 32'd4; // Link address
            core_pkg::WB_IMM: ex_wb_data = ex_imm;
            default:          ex_wb_data = ex_alu_result;
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
`include "core_defines.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`CORE_REG_AW-1:0] ra0,
    input  logic [`CORE_REG_AW-1:0] ra1,
    output logic [`CORE_XLEN-1:0]   rd0,
    output logic [`CORE_XLEN-1:0]   rd1,
    input  logic [`CORE_REG_AW-1:0] wa,
    input  logic [`CORE_XLEN-1:0]   wd,
    input  logic                    we,
    input  logic [`CORE_REG_AW-1:0] ra_dbg,
    output logic [`CORE_XLEN-1:0]   rd_dbg
);

    logic [`CORE_XLEN-1:0] regs [1:31]; // x0 has no storage

    // Write-through read, so a producer in EX feeds ID in the same cycle
    function automatic logic [`CORE_XLEN-1:0] read_port(input logic [`CORE_REG_AW-1:0] a);
        if (a == '0)
            return '0;
        else if (we && a == wa)
            return wd;
        else
            return regs[a];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd0    = read_port(ra0);
        rd1    = read_port(ra1);
        rd_dbg = read_port(ra_dbg);
    end

endmodule

// ==== tb.f ====
+incdir+hw
hw/core_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/branch_cmp.sv
hw/next_pc_sel.sv
hw/pipe_core.sv
dv/core_checker.sv
dv/core_sva.sv
dv/core_tb.sv
